// File: vlog.f
icache_pkg.sv
icache_data_ram.sv
icache_tag_store.sv
icache_refill.sv
icache_top.sv
icache_properties.sv
tb_axi_mem.sv
tb_icache.sv

// File: run.sh
#!/bin/sh
set -e

verilator --binary --assert --top-module tb_icache -f vlog.f -o tb_icache_sim

out=$(./obj_dir/tb_icache_sim)
echo "$out"

if echo "$out" | grep -qx "All checks passed"; then
    exit 0
else
    exit 1
fi

// File: tb_icache.sv
// testbench for the instruction cache with fetch and cache-op stimulus and AR counting.
module tb_icache;
    import icache_pkg::*;

    // the number of planned fetches sizes the watchdog.
    localparam int num_accesses    = 25;
    localparam int watchdog_cycles = num_accesses * (20 + 8) * 2;

    // line_b shares the index of line_a with another tag.
    localparam logic [31:0] line_a  = 32'h0001_2340;
    localparam logic [31:0] line_b  = 32'h0005_6340;
    localparam logic [31:0] uc_word = 32'h0002_0104;

    logic        aclk = 1'b0;
    logic        aresetn;
    logic        fetch_en;
    logic [31:0] fetch_addr;
    logic        fetch_cached;
    logic        fetch_stall;
    logic [31:0] fetch_rdata;
    logic        fetch_streq;
    logic        cop_en;
    cache_op_e   cop_op;
    logic [31:0] cop_addr;
    logic [3:0]  arid;
    logic [31:0] araddr;
    logic [3:0]  arlen;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic        rlast;
    logic        rvalid;

    logic        streq_seen = 1'b0;
    logic        timed_out = 1'b0;
    int          ar_count = 0;
    int          tb_errors = 0;

    icache_top i_icache_top (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .fetch_en     (fetch_en),
        .fetch_addr   (fetch_addr),
        .fetch_cached (fetch_cached),
        .fetch_stall  (fetch_stall),
        .fetch_rdata  (fetch_rdata),
        .fetch_streq  (fetch_streq),
        .cop_en       (cop_en),
        .cop_op       (cop_op),
        .cop_addr     (cop_addr),
        .arid         (arid),
        .araddr       (araddr),
        .arlen        (arlen),
        .arvalid      (arvalid),
        .arready      (arready),
        .rdata        (rdata),
        .rlast        (rlast),
        .rvalid       (rvalid)
    );

    tb_axi_mem u_axi_mem (
        .aclk    (aclk),
        .aresetn (aresetn),
        .araddr  (araddr),
        .arlen   (arlen),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rlast   (rlast),
        .rvalid  (rvalid)
    );

    bind icache_top icache_properties u_properties (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .fetch_en     (fetch_en),
        .fetch_addr   (fetch_addr),
        .fetch_streq  (fetch_streq),
        .fetch_rdata  (fetch_rdata),
        .arid         (arid),
        .araddr       (araddr),
        .arlen        (arlen),
        .arvalid      (arvalid),
        .arready      (arready),
        .refill_state (u_refill.state)
    );

    // ============================================================
    // clock, pipeline stall and AR counting
    // ============================================================

    always #5 aclk = ~aclk;

    // the pipeline stalls one cycle after the cache asks for it.
    always @(negedge aclk) streq_seen <= fetch_streq;

    initial begin
        fetch_stall = 1'b0;
        forever begin
            @(posedge aclk);
            #1 fetch_stall = streq_seen;
        end
    end

    always @(negedge aclk) begin
        if (aresetn && arvalid && arready) begin
            ar_count++;
        end
    end

    // ============================================================
    // tasks
    // ============================================================

    // presents one fetch until the cache delivers it and then idles a cycle.
    task automatic fetch_word(input logic [31:0] addr, input logic cached);
        @(posedge aclk);
        #1;
        fetch_en     = 1'b1;
        fetch_addr   = addr;
        fetch_cached = cached;
        @(negedge aclk);
        while (fetch_streq) begin
            @(negedge aclk);
        end
        @(posedge aclk);
        #1;
        fetch_en = 1'b0;
    endtask

    task automatic issue_cache_op(input cache_op_e op, input logic [31:0] addr);
        @(posedge aclk);
        #1;
        cop_en   = 1'b1;
        cop_op   = op;
        cop_addr = addr;
        @(posedge aclk);
        #1;
        cop_en = 1'b0;
    endtask

    task automatic check_ar_count(input int expected);
        if (ar_count != expected) begin
            tb_errors++;
            $display("Error at %0t: ar_count = %0d, expected %0d", $time, ar_count, expected);
        end
    endtask

    task automatic finish_run();
        int total;
        total = i_icache_top.u_properties.fail_count + tb_errors + int'(timed_out);
        $display("assertion failures: %0d, testbench errors: %0d",
            i_icache_top.u_properties.fail_count, tb_errors + int'(timed_out));
        if (total == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    endtask

    // ============================================================
    // stimulus
    // ============================================================

    initial begin
        aresetn      = 1'b0;
        fetch_en     = 1'b0;
        fetch_addr   = '0;
        fetch_cached = 1'b0;
        cop_en       = 1'b0;
        cop_op       = cop_index_inv;
        cop_addr     = '0;
        repeat (3) @(posedge aclk);
        #1 aresetn = 1'b1;

        // one refill for the whole line followed by hits.
        for (int w = 0; w < 16; w++) begin
            fetch_word(line_a + 32'(w * 4), 1'b1);
        end
        fetch_word(line_a + 32'h0c, 1'b1);
        fetch_word(line_a + 32'h1c, 1'b1);
        fetch_word(line_a + 32'h3c, 1'b1);
        check_ar_count(1);

        // eviction by a conflicting tag.
        fetch_word(line_b, 1'b1);
        check_ar_count(2);
        fetch_word(line_a + 32'h14, 1'b1);
        check_ar_count(3);

        issue_cache_op(cop_index_inv, line_a);
        fetch_word(line_a + 32'h08, 1'b1);
        check_ar_count(4);
        // the tag of line_b does not match so line_a stays resident.
        issue_cache_op(cop_hit_inv, line_b);
        fetch_word(line_a + 32'h24, 1'b1);
        check_ar_count(4);

        fetch_word(uc_word, 1'b0);
        fetch_word(uc_word, 1'b0);
        check_ar_count(6);
        finish_run();
    end

    initial begin
        repeat (watchdog_cycles) @(posedge aclk);
        timed_out = 1'b1;
        $display("watchdog expired after %0d cycles, a fetch never completed", watchdog_cycles);
        finish_run();
    end

endmodule

// File: tb_axi_mem.sv
// AXI read slave model for the instruction cache testbench with words that follow an address rule.
module tb_axi_mem (
    input  logic        aclk,
    input  logic        aresetn,
    input  logic [31:0] araddr,
    input  logic [3:0]  arlen,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic        rlast,
    output logic        rvalid
);
    integer      seed;
    int          wait_cycles;
    logic [31:0] beat_addr;
    logic [3:0]  burst_len;

    // memory content as a function of the byte address.
    function automatic logic [31:0] word_at(input logic [31:0] addr);
        return addr ^ 32'h1357_9bdf;
    endfunction

    initial begin
        seed    = 32'hf5a0_2011;
        arready = 1'b0;
        rdata   = '0;
        rlast   = 1'b0;
        rvalid  = 1'b0;
        forever begin
            @(negedge aclk);
            if (aresetn && arvalid) begin
                beat_addr   = araddr;
                burst_len   = arlen;
                wait_cycles = $unsigned($random(seed)) % 4;
                repeat (wait_cycles) @(posedge aclk);
                @(posedge aclk);
                #1 arready = 1'b1;
                @(posedge aclk);
                #1 arready = 1'b0;
                // one beat per cycle as there is no R back-pressure.
                for (int beat = 0; beat <= int'(burst_len); beat++) begin
                    rvalid = 1'b1;
                    rlast  = (beat == int'(burst_len));
                    rdata  = word_at(beat_addr);
                    beat_addr = beat_addr + 32'd4;
                    @(posedge aclk);
                    #1;
                end
                rvalid = 1'b0;
                rlast  = 1'b0;
            end
        end
    end

endmodule

// File: icache_properties.sv
// instruction cache assertions for fetch data, burst shape and AR handshake.
module icache_properties (
    input logic                      aclk,
    input logic                      aresetn,
    input logic                      fetch_en,
    input logic [31:0]               fetch_addr,
    input logic                      fetch_streq,
    input logic [31:0]               fetch_rdata,
    input logic [3:0]                arid,
    input logic [31:0]               araddr,
    input logic [3:0]                arlen,
    input logic                      arvalid,
    input logic                      arready,
    input icache_pkg::refill_state_e refill_state
);
    import icache_pkg::*;

    int   fail_count = 0;
    logic ar_fire;

    assign ar_fire = arvalid && arready;

    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        return addr ^ 32'h1357_9bdf;
    endfunction

    // ============================================================
    // fetch data
    // ============================================================

    fetch_data: assert property (@(posedge aclk) disable iff (!aresetn)
        fetch_en && !fetch_streq |-> fetch_rdata == expected_word(fetch_addr))
        else begin
            fail_count++;
            $error("Error at %0t: fetch_rdata = %h, expected %h", $time,
                $sampled(fetch_rdata), expected_word($sampled(fetch_addr)));
        end

    // ============================================================
    // AR channel
    // ============================================================

    // a line refill is a full burst from the line start.
    cached_burst: assert property (@(posedge aclk) disable iff (!aresetn)
        ar_fire && arid == id_cached |-> arlen == 4'd15 && araddr[5:0] == 6'd0)
        else begin
            fail_count++;
            $error("Error at %0t: arlen = %0d, expected 15, araddr[5:0] = %h, expected 00",
                $time, $sampled(arlen), $sampled(araddr[5:0]));
        end

    uncached_beat: assert property (@(posedge aclk) disable iff (!aresetn)
        ar_fire && arid == id_uncached |-> arlen == 4'd0)
        else begin
            fail_count++;
            $error("Error at %0t: arlen = %0d, expected 0", $time, $sampled(arlen));
        end

    // the refill engine sits idle with no request out while in reset.
    reset_idle: assert property (@(posedge aclk)
        !aresetn |-> !arvalid && refill_state == rf_idle)
        else begin
            fail_count++;
            $error("Error at %0t: arvalid = %b, u_refill.state = %0d, expected 0 and %0d",
                $time, $sampled(arvalid), $sampled(refill_state), rf_idle);
        end

    ar_stable: assert property (@(posedge aclk) disable iff (!aresetn)
        arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arlen) && $stable(arid))
        else begin
            fail_count++;
            $error("AR request changed or was withdrawn before arready at %0t", $time);
        end

endmodule

// File: icache_top.sv
// instruction cache top level joining tag store, data RAM and refill engine.
module icache_top (
    input  logic                  aclk,
    input  logic                  aresetn,
    input  logic                  fetch_en,
    input  logic [31:0]           fetch_addr,
    input  logic                  fetch_cached,
    input  logic                  fetch_stall,
    output logic [31:0]           fetch_rdata,
    output logic                  fetch_streq,
    input  logic                  cop_en,
    input  icache_pkg::cache_op_e cop_op,
    input  logic [31:0]           cop_addr,
    output logic [3:0]            arid,
    output logic [31:0]           araddr,
    output logic [3:0]            arlen,
    output logic                  arvalid,
    input  logic                  arready,
    input  logic [31:0]           rdata,
    input  logic                  rlast,
    input  logic                  rvalid
);
    import icache_pkg::*;

    logic                     line_hit;
    logic                     alloc_en;
    logic                     fill_done_en;
    logic [index_bits-1:0]    fill_index;
    logic                     ram_wen;
    logic [ram_addr_bits-1:0] ram_waddr;
    logic [31:0]              ram_wdata;
    logic [ram_addr_bits-1:0] ram_raddr;
    logic [31:0]              ram_rdata;
    logic [31:0]              uc_rdata;

    // index and word number of the fetch address.
    assign ram_raddr   = fetch_addr[offset_bits+index_bits-1:2];
    assign fetch_rdata = fetch_cached ? ram_rdata : uc_rdata;

    // ============================================================
    // instances
    // ============================================================

    icache_tag_store u_tag_store (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .lookup_addr  (fetch_addr),
        .alloc_en     (alloc_en),
        .fill_done_en (fill_done_en),
        .fill_index   (fill_index),
        .cop_en       (cop_en),
        .cop_op       (cop_op),
        .cop_addr     (cop_addr),
        .line_hit     (line_hit)
    );

    icache_data_ram u_data_ram (
        .aclk  (aclk),
        .wen   (ram_wen),
        .waddr (ram_waddr),
        .wdata (ram_wdata),
        .raddr (ram_raddr),
        .rdata (ram_rdata)
    );

    icache_refill u_refill (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .fetch_en     (fetch_en),
        .fetch_addr   (fetch_addr),
        .fetch_cached (fetch_cached),
        .fetch_stall  (fetch_stall),
        .line_hit     (line_hit),
        .arready      (arready),
        .rdata        (rdata),
        .rlast        (rlast),
        .rvalid       (rvalid),
        .fetch_streq  (fetch_streq),
        .uc_rdata     (uc_rdata),
        .alloc_en     (alloc_en),
        .fill_done_en (fill_done_en),
        .fill_index   (fill_index),
        .ram_wen      (ram_wen),
        .ram_waddr    (ram_waddr),
        .ram_wdata    (ram_wdata),
        .arid         (arid),
        .araddr       (araddr),
        .arlen        (arlen),
        .arvalid      (arvalid)
    );

endmodule

// File: icache_refill.sv
// instruction cache refill engine, AXI read bursts, RAM fill and uncached word buffer.
module icache_refill (
    input  logic                                 aclk,
    input  logic                                 aresetn,
    input  logic                                 fetch_en,
    input  logic [31:0]                          fetch_addr,
    input  logic                                 fetch_cached,
    input  logic                                 fetch_stall,
    input  logic                                 line_hit,
    input  logic                                 arready,
    input  logic [31:0]                          rdata,
    input  logic                                 rlast,
    input  logic                                 rvalid,
    output logic                                 fetch_streq,
    output logic [31:0]                          uc_rdata,
    output logic                                 alloc_en,
    output logic                                 fill_done_en,
    output logic [icache_pkg::index_bits-1:0]    fill_index,
    output logic                                 ram_wen,
    output logic [icache_pkg::ram_addr_bits-1:0] ram_waddr,
    output logic [31:0]                          ram_wdata,
    output logic [3:0]                           arid,
    output logic [31:0]                          araddr,
    output logic [3:0]                           arlen,
    output logic                                 arvalid
);
    import icache_pkg::*;

    refill_state_e state;

    // latched request.
    logic [31:0]                         req_addr;
    logic                                req_cached;
    logic [index_bits-1:0]               req_index;

    // beat counter, word number within the line.
    logic [ram_addr_bits-index_bits-1:0] r_cnt;

    // one-word uncached buffer.
    logic [31:0]                         uc_data;
    logic [31:0]                         uc_addr;
    logic                                uc_valid;
    logic                                uc_hit;

    logic                                miss;
    logic                                beat;

    // ============================================================
    // fetch side
    // ============================================================

    assign uc_hit      = uc_valid && (uc_addr == fetch_addr);
    assign fetch_streq = fetch_en && (fetch_cached ? !line_hit : !uc_hit);
    assign uc_rdata    = uc_data;

    assign miss        = (state == rf_idle) && fetch_streq;
    assign beat        = (state == rf_data) && rvalid;

    // tag store commands.
    assign req_index    = req_addr[offset_bits +: index_bits];
    assign alloc_en     = miss && fetch_cached;
    assign fill_done_en = (state == rf_done) && req_cached;
    assign fill_index   = req_index;

    // AR fields only change on a new miss, so they hold through the address phase.
    assign araddr = req_addr;
    assign arid   = req_cached ? id_cached : id_uncached;
    assign arlen  = req_cached ? 4'(line_words - 1) : 4'd0;

    // ============================================================
    // control FSM
    // ============================================================

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state    <= rf_idle;
            arvalid  <= 1'b0;
            r_cnt    <= '0;
            ram_wen  <= 1'b0;
            uc_valid <= 1'b0;
        end else begin
            ram_wen <= 1'b0;
            case (state)
                rf_idle: begin
                    if (miss) begin
                        r_cnt <= '0;
                        state <= rf_addr;
                    end
                end
                rf_addr: begin
                    if (arvalid && arready) begin
                        arvalid <= 1'b0;
                        state   <= rf_data;
                    end else begin
                        arvalid <= 1'b1;
                    end
                end
                rf_data: begin
                    if (rvalid) begin
                        if (req_cached) begin
                            ram_wen <= 1'b1;
                            r_cnt   <= r_cnt + 1'b1;
                        end else if (rlast) begin
                            uc_valid <= 1'b1;
                        end
                        if (rlast) begin
                            state <= rf_done;
                        end
                    end
                end
                rf_done: begin
                    // wait for the pipeline to catch up with the stall request.
                    if (fetch_stall == fetch_streq) begin
                        uc_valid <= 1'b0;
                        state    <= rf_idle;
                    end
                end
                default: begin
                    state <= rf_idle;
                end
            endcase
        end
    end

    // ============================================================
    // request and data path
    // ============================================================

    always_ff @(posedge aclk) begin
        if (miss) begin
            req_cached <= fetch_cached;
            if (fetch_cached) begin
                req_addr <= {fetch_addr[31:offset_bits], {offset_bits{1'b0}}};
            end else begin
                req_addr <= fetch_addr;
            end
        end
        if (beat) begin
            ram_waddr <= {req_index, r_cnt};
            ram_wdata <= rdata;
            if (!req_cached) begin
                uc_data <= rdata;
                uc_addr <= req_addr;
            end
        end
    end

endmodule

// File: icache_tag_store.sv
// instruction cache tag and valid arrays with hit compare, allocation, fill and invalidate.
module icache_tag_store (
    input  logic                              aclk,
    input  logic                              aresetn,
    input  logic [31:0]                       lookup_addr,
    input  logic                              alloc_en,
    input  logic                              fill_done_en,
    input  logic [icache_pkg::index_bits-1:0] fill_index,
    input  logic                              cop_en,
    input  icache_pkg::cache_op_e             cop_op,
    input  logic [31:0]                       cop_addr,
    output logic                              line_hit
);
    import icache_pkg::*;

    logic [tag_bits-1:0]   tags [num_lines];
    logic [num_lines-1:0]  valid;

    logic [index_bits-1:0] lk_index;
    logic [tag_bits-1:0]   lk_tag;
    logic [index_bits-1:0] cop_index;
    logic [tag_bits-1:0]   cop_tag;
    logic                  cop_match;

    assign lk_index  = lookup_addr[offset_bits +: index_bits];
    assign lk_tag    = lookup_addr[31 -: tag_bits];
    assign cop_index = cop_addr[offset_bits +: index_bits];
    assign cop_tag   = cop_addr[31 -: tag_bits];

    assign line_hit  = valid[lk_index] && (tags[lk_index] == lk_tag);
    assign cop_match = (tags[cop_index] == cop_tag);

    // ============================================================
    // tag array
    // ============================================================

    // the tag is written when a miss allocates the line.
    always_ff @(posedge aclk) begin
        if (alloc_en) begin
            tags[lk_index] <= lk_tag;
        end
    end

    // ============================================================
    // valid bits
    // ============================================================

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            valid <= '0;
        end else begin
            if (alloc_en) begin
                valid[lk_index] <= 1'b0;
            end
            if (cop_en) begin
                if (cop_op == cop_index_inv) begin
                    valid[cop_index] <= 1'b0;
                end else if (cop_op == cop_hit_inv && cop_match) begin
                    valid[cop_index] <= 1'b0;
                end
            end
            // last assignment, so a completing fill beats an invalidate.
            if (fill_done_en) begin
                valid[fill_index] <= 1'b1;
            end
        end
    end

endmodule

// File: icache_data_ram.sv
// instruction cache data RAM, one synchronous write port and one asynchronous read port.
module icache_data_ram (
    input  logic                                 aclk,
    input  logic                                 wen,
    input  logic [icache_pkg::ram_addr_bits-1:0] waddr,
    input  logic [31:0]                          wdata,
    input  logic [icache_pkg::ram_addr_bits-1:0] raddr,
    output logic [31:0]                          rdata
);
    import icache_pkg::*;

    // one word per entry, lines laid out back to back.
    logic [31:0] mem [num_lines*line_words];

    // ============================================================
    // write port
    // ============================================================

    always_ff @(posedge aclk) begin
        if (wen) begin
            mem[waddr] <= wdata;
        end
    end

    // ============================================================
    // read port
    // ============================================================

    // combinational read so a hit returns data in the request cycle.
    assign rdata = mem[raddr];

endmodule

// File: icache_pkg.sv
// instruction cache package with geometry, AXI IDs, refill states and cache op codes.
package icache_pkg;

    // ============================================================
    // geometry
    // ============================================================

    // 16 words of 4 bytes per line.
    localparam int line_words = 16;

    // byte offset inside a line.
    localparam int offset_bits = 6;

    // line index, 64 lines direct-mapped.
    localparam int index_bits = 6;
    localparam int num_lines = 64;

    // physical tag above index and offset.
    localparam int tag_bits = 20;

    // data RAM word address, index and word number together.
    localparam int ram_addr_bits = 10;

    // ============================================================
    // AXI read IDs
    // ============================================================

    // line refill bursts.
    localparam logic [3:0] id_cached = 4'd3;

    // single-word uncached reads.
    localparam logic [3:0] id_uncached = 4'd2;

    // ============================================================
    // enums
    // ============================================================

    // refill engine states.
    typedef enum logic [1:0] {
        rf_idle,
        rf_addr,
        rf_data,
        rf_done
    } refill_state_e;

    // cache maintenance operations.
    typedef enum logic [1:0] {
        cop_index_inv,
        cop_hit_inv
    } cache_op_e;

endpackage
